//--- hw/ibex_ctrl_defs.svh
/*
 * ibex control shell widths, shared by RTL and testbench
 */
`ifndef IBEX_CTRL_DEFS_SVH
`define IBEX_CTRL_DEFS_SVH

// exception pc and address
`define IBEX_CTRL_ADDR_W 32
// one entropy word
`define IBEX_CTRL_RND_W 32
// nmi sources: escalation and watchdog
`define IBEX_CTRL_NMI_W 2
// sticky error causes
`define IBEX_CTRL_ERR_W 3
// inputs crossing into clk_i
`define IBEX_CTRL_SYNC_W 4

`endif

//--- hw/ibex_ctrl_pkg.sv
/*
 * ibex control shell types: FSM states and bit positions in shared vectors
 */
`default_nettype none

package ibex_ctrl_pkg;

  // local fetch enable, latches off on a fatal core error
  typedef enum logic {
    FETCH_ON     = 1'b0,
    FETCH_LOCKED = 1'b1
  } fetch_state_e;

  typedef enum logic {
    RND_EMPTY = 1'b0,
    RND_FULL  = 1'b1
  } rnd_state_e;

  // position in nmi state, enable and clear vectors
  typedef enum logic {
    NMI_ALERT = 1'b0,
    NMI_WDOG  = 1'b1
  } nmi_src_e;

  typedef enum logic [1:0] {
    ERR_FATAL_INTG = 2'd0,
    ERR_FATAL_CORE = 2'd1,
    ERR_RECOV_CORE = 2'd2
  } err_bit_e;

  // lanes of the input synchronizer
  typedef enum logic [1:0] {
    SYNC_LC_EN    = 2'd0,
    SYNC_PWR_EN   = 2'd1,
    SYNC_ESC_NMI  = 2'd2,
    SYNC_WDOG_NMI = 2'd3
  } sync_bit_e;

endpackage

`default_nettype wire

//--- hw/core_event_if.sv
/*
 * core fault events and exception context, core side to fault recorder
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

interface core_event_if;

  logic                         ibus_intg_err;
  logic                         dbus_intg_err;
  logic                         alert_minor;
  logic                         alert_major_internal;
  logic                         alert_major_bus;
  logic                         double_fault;
  logic [`IBEX_CTRL_ADDR_W-1:0] exception_pc;
  logic [`IBEX_CTRL_ADDR_W-1:0] exception_addr;

  // driven from the core event pins
  modport src (
    output ibus_intg_err, dbus_intg_err, alert_minor, alert_major_internal,
           alert_major_bus, double_fault, exception_pc, exception_addr
  );

  modport sink (
    input  ibus_intg_err, dbus_intg_err, alert_minor, alert_major_internal,
           alert_major_bus, double_fault, exception_pc, exception_addr
  );

endinterface

`default_nettype wire

//--- hw/ibex_ctrl_sync.sv
/*
 * two-flop synchronizer bank for asynchronous enables and nmi sources
 */
`timescale 1ns/100ps
`default_nettype none

module ibex_ctrl_sync #(
  parameter int unsigned Width = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Width-1:0] stage1_q;
  logic [Width-1:0] stage2_q;

  // first stage may go metastable, second settles it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= '0;
      stage2_q <= '0;
    end else begin
      stage1_q <= d_i;
      stage2_q <= stage1_q;
    end
  end

  assign q_o = stage2_q;

endmodule

`default_nettype wire

//--- hw/fetch_enable_fsm.sv
/*
 * fetch enable gating, locks fetch off for good on a fatal core error
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_enable_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic lc_en_i,
  input  logic pwr_en_i,
  input  logic fatal_core_err_i,
  output logic fetch_enable_o
);

  ibex_ctrl_pkg::fetch_state_e state_q;
  ibex_ctrl_pkg::fetch_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ibex_ctrl_pkg::FETCH_ON: begin
        if (fatal_core_err_i) begin
          state_d = ibex_ctrl_pkg::FETCH_LOCKED;
        end
      end
      // no way back short of reset
      default: state_d = ibex_ctrl_pkg::FETCH_LOCKED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ibex_ctrl_pkg::FETCH_ON;
    end else begin
      state_q <= state_d;
    end
  end

  // local enable and both synchronized enables
  assign fetch_enable_o = (state_q == ibex_ctrl_pkg::FETCH_ON) & lc_en_i & pwr_en_i;

endmodule

`default_nettype wire

//--- hw/nmi_ctrl.sv
/*
 * nmi state: sticky per source, software maskable and clearable
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module nmi_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [`IBEX_CTRL_NMI_W-1:0] nmi_src_i,
  input  logic [`IBEX_CTRL_NMI_W-1:0] nmi_enable_i,
  input  logic [`IBEX_CTRL_NMI_W-1:0] nmi_clear_i,
  output logic [`IBEX_CTRL_NMI_W-1:0] nmi_state_o,
  output logic                        irq_nm_o
);

  logic [`IBEX_CTRL_NMI_W-1:0] state_q;
  logic [`IBEX_CTRL_NMI_W-1:0] state_d;

  // write-one-to-clear, a pending source wins over the clear
  assign state_d = (state_q & ~nmi_clear_i) | nmi_src_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign nmi_state_o = state_q;

  // masked sources stay recorded but raise no request
  assign irq_nm_o = |(state_q & nmi_enable_i);

endmodule

`default_nettype wire

//--- hw/fault_recorder.sv
/*
 * fault recorder: sticky error causes, alert levels and crash dump of
 * the previous exception on a double fault
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module fault_recorder (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  core_event_if.sink                   ev,
  output logic [`IBEX_CTRL_ERR_W-1:0]  err_status_o,
  output logic                         alert_fatal_o,
  output logic                         alert_recov_o,
  output logic                         fatal_core_err_o,
  output logic                         prev_valid_o,
  output logic [`IBEX_CTRL_ADDR_W-1:0] prev_pc_o,
  output logic [`IBEX_CTRL_ADDR_W-1:0] prev_addr_o
);

  logic [`IBEX_CTRL_ERR_W-1:0]  err_event;
  logic [`IBEX_CTRL_ERR_W-1:0]  err_q;
  logic                         fatal_core;
  logic                         recov_q;
  logic                         prev_valid_q;
  logic [`IBEX_CTRL_ADDR_W-1:0] prev_pc_q;
  logic [`IBEX_CTRL_ADDR_W-1:0] prev_addr_q;

  ////////////////////////////////////////
  // error causes
  ////////////////////////////////////////

  // goes straight to the fetch lock, no register in between
  assign fatal_core = ev.alert_major_internal | ev.double_fault;

  always_comb begin
    err_event = '0;
    err_event[ibex_ctrl_pkg::ERR_FATAL_INTG] = ev.ibus_intg_err | ev.dbus_intg_err |
                                               ev.alert_major_bus;
    err_event[ibex_ctrl_pkg::ERR_FATAL_CORE] = fatal_core;
    err_event[ibex_ctrl_pkg::ERR_RECOV_CORE] = ev.alert_minor;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q   <= '0;
      recov_q <= 1'b0;
    end else begin
      err_q   <= err_q | err_event;
      recov_q <= ev.alert_minor;
    end
  end

  assign err_status_o     = err_q;
  assign fatal_core_err_o = fatal_core;
  assign alert_fatal_o    = err_q[ibex_ctrl_pkg::ERR_FATAL_INTG] |
                            err_q[ibex_ctrl_pkg::ERR_FATAL_CORE];
  // recoverable alert follows the event, it is not sticky
  assign alert_recov_o    = recov_q;

  ////////////////////////////////////////
  // crash dump
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_valid_q <= 1'b0;
    end else if (ev.double_fault) begin
      prev_valid_q <= 1'b1;
    end
  end

  // reloaded on every double fault
  always_ff @(posedge clk_i) begin
    if (ev.double_fault) begin
      prev_pc_q   <= ev.exception_pc;
      prev_addr_q <= ev.exception_addr;
    end
  end

  assign prev_valid_o = prev_valid_q;
  assign prev_pc_o    = prev_pc_q;
  assign prev_addr_o  = prev_addr_q;

endmodule

`default_nettype wire

//--- hw/rnd_buffer.sv
/*
 * single word entropy buffer, filled by req/ack and emptied by a read
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module rnd_buffer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rnd_re_i,
  input  logic                        edn_ack_i,
  input  logic                        edn_fips_i,
  input  logic [`IBEX_CTRL_RND_W-1:0] edn_bits_i,
  output logic                        edn_req_o,
  output logic                        rnd_valid_o,
  output logic                        rnd_fips_o,
  output logic [`IBEX_CTRL_RND_W-1:0] rnd_data_o
);

  ibex_ctrl_pkg::rnd_state_e   state_q;
  ibex_ctrl_pkg::rnd_state_e   state_d;
  logic [`IBEX_CTRL_RND_W-1:0] data_q;
  logic [`IBEX_CTRL_RND_W-1:0] data_d;
  logic                        fips_q;
  logic                        fips_d;
  logic                        req;

  // ask for entropy only while empty
  assign req = (state_q == ibex_ctrl_pkg::RND_EMPTY);

  always_comb begin
    state_d = state_q;
    data_d  = data_q;
    fips_d  = fips_q;
    // a read drops the word even if a new one arrives
    if (rnd_re_i) begin
      state_d = ibex_ctrl_pkg::RND_EMPTY;
      data_d  = '0;
      fips_d  = 1'b0;
    end else if (req && edn_ack_i) begin
      state_d = ibex_ctrl_pkg::RND_FULL;
      data_d  = edn_bits_i;
      fips_d  = edn_fips_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ibex_ctrl_pkg::RND_EMPTY;
      data_q  <= '0;
      fips_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      data_q  <= data_d;
      fips_q  <= fips_d;
    end
  end

  assign edn_req_o   = req;
  assign rnd_valid_o = (state_q == ibex_ctrl_pkg::RND_FULL);
  assign rnd_fips_o  = fips_q;
  assign rnd_data_o  = data_q;

endmodule

`default_nettype wire

//--- hw/ibex_ctrl_top.sv
/*
 * ibex control shell top: fetch gating, nmi, fault recording, entropy buffer
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module ibex_ctrl_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // cpu enables, asynchronous
  input  logic                         lc_cpu_en_i,
  input  logic                         pwrmgr_cpu_en_i,
  // nmi sources, asynchronous
  input  logic                         esc_nmi_i,
  input  logic                         wdog_nmi_i,
  input  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_enable_i,
  input  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_clear_i,
  // core events
  input  logic                         ibus_intg_err_i,
  input  logic                         dbus_intg_err_i,
  input  logic                         alert_minor_i,
  input  logic                         alert_major_internal_i,
  input  logic                         alert_major_bus_i,
  input  logic                         double_fault_i,
  input  logic [`IBEX_CTRL_ADDR_W-1:0] exception_pc_i,
  input  logic [`IBEX_CTRL_ADDR_W-1:0] exception_addr_i,
  // entropy
  input  logic                         rnd_re_i,
  input  logic                         edn_ack_i,
  input  logic [`IBEX_CTRL_RND_W-1:0]  edn_bits_i,
  input  logic                         edn_fips_i,
  output logic                         fetch_enable_o,
  output logic                         irq_nm_o,
  output logic [`IBEX_CTRL_NMI_W-1:0]  nmi_state_o,
  output logic [`IBEX_CTRL_ERR_W-1:0]  err_status_o,
  output logic                         alert_fatal_o,
  output logic                         alert_recov_o,
  output logic                         prev_valid_o,
  output logic [`IBEX_CTRL_ADDR_W-1:0] prev_pc_o,
  output logic [`IBEX_CTRL_ADDR_W-1:0] prev_addr_o,
  output logic                         edn_req_o,
  output logic                         rnd_valid_o,
  output logic [`IBEX_CTRL_RND_W-1:0]  rnd_data_o,
  output logic                         rnd_fips_o
);

  logic [`IBEX_CTRL_SYNC_W-1:0] sync_d;
  logic [`IBEX_CTRL_SYNC_W-1:0] sync_q;
  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_src;
  logic                         fatal_core_err;

  core_event_if u_core_ev ();

  ////////////////////////////////////////
  // input synchronization
  ////////////////////////////////////////

  assign sync_d[ibex_ctrl_pkg::SYNC_LC_EN]    = lc_cpu_en_i;
  assign sync_d[ibex_ctrl_pkg::SYNC_PWR_EN]   = pwrmgr_cpu_en_i;
  assign sync_d[ibex_ctrl_pkg::SYNC_ESC_NMI]  = esc_nmi_i;
  assign sync_d[ibex_ctrl_pkg::SYNC_WDOG_NMI] = wdog_nmi_i;

  ibex_ctrl_sync #(
    .Width(`IBEX_CTRL_SYNC_W)
  ) u_sync (
    .clk_i,
    .rst_ni,
    .d_i (sync_d),
    .q_o (sync_q)
  );

  // escalation feeds the alert nmi lane
  assign nmi_src[ibex_ctrl_pkg::NMI_ALERT] = sync_q[ibex_ctrl_pkg::SYNC_ESC_NMI];
  assign nmi_src[ibex_ctrl_pkg::NMI_WDOG]  = sync_q[ibex_ctrl_pkg::SYNC_WDOG_NMI];

  ////////////////////////////////////////
  // control blocks
  ////////////////////////////////////////

  fetch_enable_fsm u_fetch_en (
    .clk_i,
    .rst_ni,
    .lc_en_i          (sync_q[ibex_ctrl_pkg::SYNC_LC_EN]),
    .pwr_en_i         (sync_q[ibex_ctrl_pkg::SYNC_PWR_EN]),
    .fatal_core_err_i (fatal_core_err),
    .fetch_enable_o
  );

  nmi_ctrl u_nmi (
    .clk_i,
    .rst_ni,
    .nmi_src_i (nmi_src),
    .nmi_enable_i,
    .nmi_clear_i,
    .nmi_state_o,
    .irq_nm_o
  );

  assign u_core_ev.ibus_intg_err        = ibus_intg_err_i;
  assign u_core_ev.dbus_intg_err        = dbus_intg_err_i;
  assign u_core_ev.alert_minor          = alert_minor_i;
  assign u_core_ev.alert_major_internal = alert_major_internal_i;
  assign u_core_ev.alert_major_bus      = alert_major_bus_i;
  assign u_core_ev.double_fault         = double_fault_i;
  assign u_core_ev.exception_pc         = exception_pc_i;
  assign u_core_ev.exception_addr       = exception_addr_i;

  fault_recorder u_faults (
    .clk_i,
    .rst_ni,
    .ev               (u_core_ev.sink),
    .err_status_o,
    .alert_fatal_o,
    .alert_recov_o,
    .fatal_core_err_o (fatal_core_err),
    .prev_valid_o,
    .prev_pc_o,
    .prev_addr_o
  );

  rnd_buffer u_rnd (
    .clk_i,
    .rst_ni,
    .rnd_re_i,
    .edn_ack_i,
    .edn_fips_i,
    .edn_bits_i,
    .edn_req_o,
    .rnd_valid_o,
    .rnd_fips_o,
    .rnd_data_o
  );

endmodule

`default_nettype wire

//--- testbench/ibex_ctrl_sva.sv
/*
 * bound checks on the control shell ports: fetch lock, entropy state,
 * nmi masking and causes of error status bits
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module ibex_ctrl_sva (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        ibus_intg_err_i,
  input logic                        dbus_intg_err_i,
  input logic                        alert_minor_i,
  input logic                        alert_major_internal_i,
  input logic                        alert_major_bus_i,
  input logic                        double_fault_i,
  input logic [`IBEX_CTRL_NMI_W-1:0] nmi_enable_i,
  input logic                        fetch_enable_o,
  input logic                        irq_nm_o,
  input logic [`IBEX_CTRL_ERR_W-1:0] err_status_o,
  input logic                        edn_req_o,
  input logic                        rnd_valid_o
);

  int unsigned assert_fail_cnt = 0;
  logic        fatal_seen_q;

  // any fatal core event since reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fatal_seen_q <= 1'b0;
    end else if (double_fault_i || alert_major_internal_i) begin
      fatal_seen_q <= 1'b1;
    end
  end

  fetch_locked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fatal_seen_q |-> !fetch_enable_o)
    else begin
      $error("fetch enabled after a fatal core error");
      assert_fail_cnt++;
    end

  rnd_state_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(edn_req_o && rnd_valid_o))
    else begin
      $error("entropy request while the buffer holds a word");
      assert_fail_cnt++;
    end

  nmi_mask_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nmi_enable_i == '0) |-> !irq_nm_o)
    else begin
      $error("nmi request with all sources masked");
      assert_fail_cnt++;
    end

  ////////////////////////////////////////
  // error status causes
  ////////////////////////////////////////

  intg_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(err_status_o[ibex_ctrl_pkg::ERR_FATAL_INTG]) |->
      $past(ibus_intg_err_i || dbus_intg_err_i || alert_major_bus_i))
    else begin
      $error("integrity error bit set without an integrity event");
      assert_fail_cnt++;
    end

  core_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(err_status_o[ibex_ctrl_pkg::ERR_FATAL_CORE]) |->
      $past(alert_major_internal_i || double_fault_i))
    else begin
      $error("fatal core bit set without a fatal core event");
      assert_fail_cnt++;
    end

  recov_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(err_status_o[ibex_ctrl_pkg::ERR_RECOV_CORE]) |-> $past(alert_minor_i))
    else begin
      $error("recoverable bit set without a minor alert");
      assert_fail_cnt++;
    end

endmodule

bind ibex_ctrl_top ibex_ctrl_sva u_sva (.*);

`default_nettype wire

//--- testbench/ibex_ctrl_tb.sv
/*
 * ibex control shell testbench covering reset, entropy buffer, nmi,
 * fetch gating and faults
 */
`timescale 1ns/100ps
`default_nettype none
`include "ibex_ctrl_defs.svh"

module ibex_ctrl_tb;

  localparam int drive_dly   = 10;
  localparam int probe_fetch = 0;
  localparam int probe_irq   = 1;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         lc_cpu_en_i;
  logic                         pwrmgr_cpu_en_i;
  logic                         esc_nmi_i;
  logic                         wdog_nmi_i;
  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_enable_i;
  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_clear_i;
  logic                         ibus_intg_err_i;
  logic                         dbus_intg_err_i;
  logic                         alert_minor_i;
  logic                         alert_major_internal_i;
  logic                         alert_major_bus_i;
  logic                         double_fault_i;
  logic [`IBEX_CTRL_ADDR_W-1:0] exception_pc_i;
  logic [`IBEX_CTRL_ADDR_W-1:0] exception_addr_i;
  logic                         rnd_re_i;
  logic                         edn_ack_i;
  logic [`IBEX_CTRL_RND_W-1:0]  edn_bits_i;
  logic                         edn_fips_i;
  logic                         fetch_enable_o;
  logic                         irq_nm_o;
  logic [`IBEX_CTRL_NMI_W-1:0]  nmi_state_o;
  logic [`IBEX_CTRL_ERR_W-1:0]  err_status_o;
  logic                         alert_fatal_o;
  logic                         alert_recov_o;
  logic                         prev_valid_o;
  logic [`IBEX_CTRL_ADDR_W-1:0] prev_pc_o;
  logic [`IBEX_CTRL_ADDR_W-1:0] prev_addr_o;
  logic                         edn_req_o;
  logic                         rnd_valid_o;
  logic [`IBEX_CTRL_RND_W-1:0]  rnd_data_o;
  logic                         rnd_fips_o;

  // reference model state
  logic                         m_rnd_full;
  logic [`IBEX_CTRL_RND_W-1:0]  m_rnd_data;
  logic                         m_rnd_fips;
  logic [`IBEX_CTRL_ERR_W-1:0]  m_err;
  logic                         m_prev_valid;
  logic [`IBEX_CTRL_ADDR_W-1:0] m_prev_pc;
  logic [`IBEX_CTRL_ADDR_W-1:0] m_prev_addr;

  integer seed = 27986;

  ibex_ctrl_top u_ibex_ctrl_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      report_failure($sformatf("Mismatch at %0t: %s expected %h, actual %h",
                               $time, name, exp, act));
    end
  endtask

  function automatic logic probe(input int sel);
    if (sel == probe_fetch) begin
      return fetch_enable_o;
    end
    return irq_nm_o;
  endfunction

  task automatic wait_level(input string name, input int sel, input logic level,
                            input int max_cycles);
    int n;
    bit hit;
    hit = 1'b0;
    for (n = 0; n < max_cycles && !hit; n++) begin
      @(negedge clk_i);
      hit = (probe(sel) === level);
    end
    if (!hit) begin
      report_failure($sformatf("%s did not reach %b within %0d cycles",
                               name, level, max_cycles));
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_drive();
    @(posedge clk_i);
    #drive_dly;
  endtask

  task automatic rnd_step(input logic re, input logic ack, input logic [31:0] bits,
                          input logic fips);
    next_drive();
    rnd_re_i   = re;
    edn_ack_i  = ack;
    edn_bits_i = bits;
    edn_fips_i = fips;
    @(posedge clk_i);
    // read wins and a word is only taken while empty
    if (re) begin
      m_rnd_full = 1'b0;
      m_rnd_data = '0;
      m_rnd_fips = 1'b0;
    end else if (!m_rnd_full && ack) begin
      m_rnd_full = 1'b1;
      m_rnd_data = bits;
      m_rnd_fips = fips;
    end
    #drive_dly;
    rnd_re_i  = 1'b0;
    edn_ack_i = 1'b0;
    @(negedge clk_i);
    check_val("edn_req_o", !m_rnd_full, edn_req_o);
    check_val("rnd_valid_o", m_rnd_full, rnd_valid_o);
    check_val("rnd_data_o", m_rnd_data, rnd_data_o);
    check_val("rnd_fips_o", m_rnd_fips, rnd_fips_o);
  endtask

  task automatic nmi_sequence(input ibex_ctrl_pkg::nmi_src_e src);
    logic [`IBEX_CTRL_NMI_W-1:0] sel;
    sel      = '0;
    sel[src] = 1'b1;
    next_drive();
    nmi_enable_i = sel;
    if (src == ibex_ctrl_pkg::NMI_WDOG) begin
      wdog_nmi_i = 1'b1;
    end else begin
      esc_nmi_i = 1'b1;
    end
    next_drive();
    wdog_nmi_i = 1'b0;
    esc_nmi_i  = 1'b0;
    wait_level("irq_nm_o", probe_irq, 1'b1, 4);
    check_val("nmi_state_o", sel, nmi_state_o);
    // masked source keeps its state bit
    next_drive();
    nmi_enable_i = '0;
    @(negedge clk_i);
    check_val("irq_nm_o", 1'b0, irq_nm_o);
    check_val("nmi_state_o", sel, nmi_state_o);
    next_drive();
    nmi_clear_i = sel;
    next_drive();
    nmi_clear_i = '0;
    @(negedge clk_i);
    check_val("nmi_state_o", '0, nmi_state_o);
  endtask

  task automatic gate_check(input bit use_pwr);
    next_drive();
    if (use_pwr) begin
      pwrmgr_cpu_en_i = 1'b0;
    end else begin
      lc_cpu_en_i = 1'b0;
    end
    wait_level("fetch_enable_o", probe_fetch, 1'b0, 3);
    next_drive();
    if (use_pwr) begin
      pwrmgr_cpu_en_i = 1'b1;
    end else begin
      lc_cpu_en_i = 1'b1;
    end
    wait_level("fetch_enable_o", probe_fetch, 1'b1, 3);
  endtask

  // ev bits from msb are ibus, dbus, minor, major internal, major bus and double fault
  task automatic fault_step(input logic [5:0] ev, input logic [31:0] pc,
                            input logic [31:0] addr);
    next_drive();
    {ibus_intg_err_i, dbus_intg_err_i, alert_minor_i, alert_major_internal_i,
     alert_major_bus_i, double_fault_i} = ev;
    exception_pc_i   = pc;
    exception_addr_i = addr;
    @(posedge clk_i);
    if (ev[5] | ev[4] | ev[1]) begin
      m_err[ibex_ctrl_pkg::ERR_FATAL_INTG] = 1'b1;
    end
    if (ev[2] | ev[0]) begin
      m_err[ibex_ctrl_pkg::ERR_FATAL_CORE] = 1'b1;
    end
    if (ev[3]) begin
      m_err[ibex_ctrl_pkg::ERR_RECOV_CORE] = 1'b1;
    end
    if (ev[0]) begin
      m_prev_valid = 1'b1;
      m_prev_pc    = pc;
      m_prev_addr  = addr;
    end
    #drive_dly;
    {ibus_intg_err_i, dbus_intg_err_i, alert_minor_i, alert_major_internal_i,
     alert_major_bus_i, double_fault_i} = '0;
    @(negedge clk_i);
    check_val("err_status_o", m_err, err_status_o);
    check_val("alert_fatal_o", m_err[ibex_ctrl_pkg::ERR_FATAL_INTG] |
              m_err[ibex_ctrl_pkg::ERR_FATAL_CORE], alert_fatal_o);
    check_val("alert_recov_o", ev[3], alert_recov_o);
    check_val("prev_valid_o", m_prev_valid, prev_valid_o);
    if (m_prev_valid) begin
      check_val("prev_pc_o", m_prev_pc, prev_pc_o);
      check_val("prev_addr_o", m_prev_addr, prev_addr_o);
    end
  endtask

  always @(negedge clk_i) begin
    if (u_ibex_ctrl_top.u_sva.assert_fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT ports failed");
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int n;
    rst_ni = 1'b0;
    {lc_cpu_en_i, pwrmgr_cpu_en_i, esc_nmi_i, wdog_nmi_i} = '0;
    nmi_enable_i = '0;
    nmi_clear_i  = '0;
    {ibus_intg_err_i, dbus_intg_err_i, alert_minor_i, alert_major_internal_i,
     alert_major_bus_i, double_fault_i} = '0;
    exception_pc_i   = '0;
    exception_addr_i = '0;
    {rnd_re_i, edn_ack_i, edn_fips_i} = '0;
    edn_bits_i   = '0;
    m_rnd_full   = 1'b0;
    m_rnd_data   = '0;
    m_rnd_fips   = 1'b0;
    m_err        = '0;
    m_prev_valid = 1'b0;
    m_prev_pc    = '0;
    m_prev_addr  = '0;
    repeat (5) @(posedge clk_i);
    #drive_dly;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("edn_req_o", 1'b1, edn_req_o);
    check_val("rnd_valid_o", 1'b0, rnd_valid_o);
    check_val("err_status_o", '0, err_status_o);
    check_val("prev_valid_o", 1'b0, prev_valid_o);
    check_val("irq_nm_o", 1'b0, irq_nm_o);
    check_val("fetch_enable_o", 1'b0, fetch_enable_o);
    next_drive();
    lc_cpu_en_i     = 1'b1;
    pwrmgr_cpu_en_i = 1'b1;
    wait_level("fetch_enable_o", probe_fetch, 1'b1, 3);

    // fill and back-pressure, then reads with an ack while full and while empty
    rnd_step(1'b0, 1'b1, $random(seed), 1'b1);
    rnd_step(1'b0, 1'b1, $random(seed), 1'b0);
    rnd_step(1'b1, 1'b0, '0, 1'b0);
    rnd_step(1'b0, 1'b1, $random(seed), 1'b0);
    rnd_step(1'b1, 1'b1, $random(seed), 1'b1);
    rnd_step(1'b1, 1'b1, $random(seed), 1'b1);

    nmi_sequence(ibex_ctrl_pkg::NMI_WDOG);
    nmi_sequence(ibex_ctrl_pkg::NMI_ALERT);

    gate_check(1'b0);
    gate_check(1'b1);

    fault_step(6'b001000, '0, '0);
    fault_step(6'b100000, '0, '0);
    fault_step(6'b010000, '0, '0);
    fault_step(6'b000010, '0, '0);
    fault_step(6'b000001, $random(seed), $random(seed));
    fault_step(6'b000001, $random(seed), $random(seed));
    // locked for good with both enables still high
    for (n = 0; n < 8; n++) begin
      @(negedge clk_i);
      check_val("fetch_enable_o", 1'b0, fetch_enable_o);
    end

    if (u_ibex_ctrl_top.u_sva.assert_fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT ports failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- ibex_ctrl.f
+incdir+hw
hw/ibex_ctrl_pkg.sv
hw/core_event_if.sv
hw/ibex_ctrl_sync.sv
hw/fetch_enable_fsm.sv
hw/nmi_ctrl.sv
hw/fault_recorder.sv
hw/rnd_buffer.sv
hw/ibex_ctrl_top.sv
testbench/ibex_ctrl_sva.sv
testbench/ibex_ctrl_tb.sv

//--- Bender.yml
package:
  name: ibex_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/ibex_ctrl_pkg.sv
      - hw/core_event_if.sv
      - hw/ibex_ctrl_sync.sv
      - hw/fetch_enable_fsm.sv
      - hw/nmi_ctrl.sv
      - hw/fault_recorder.sv
      - hw/rnd_buffer.sv
      - hw/ibex_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/ibex_ctrl_sva.sv
      - testbench/ibex_ctrl_tb.sv
